// ==== rtl/rn_macros.svh ====
/* Sizes of the rename slice. Tag and index types in cpu_types_pkg are derived from these,
   so RN_NUM_PREGS and RN_ROB_DEPTH must stay powers of two */
`ifndef RN_MACROS_SVH
`define RN_MACROS_SVH

// Slots renamed per group
`define RN_WIDTH 4

// Architectural register file, register zero is hardwired
`define RN_NUM_AREGS 32

// Physical register file, the upper part starts out free
`define RN_NUM_PREGS 64

// Reorder buffer entries
`define RN_ROB_DEPTH 16

`endif

// ==== rtl/cpu_types_pkg.sv ====
/* Register tag and ROB index types, sized from rn_macros.svh */
`default_nettype none

`include "rn_macros.svh"

package cpu_types_pkg;

	// Architectural register number
	typedef logic [$clog2(`RN_NUM_AREGS)-1:0] areg_t;

	// Physical register tag
	typedef logic [$clog2(`RN_NUM_PREGS)-1:0] preg_t;

	// ROB index, wraps with the buffer depth
	typedef logic [$clog2(`RN_ROB_DEPTH)-1:0] rob_idx_t;

	// ROB occupancy needs one more bit to hold a full buffer
	typedef logic [$clog2(`RN_ROB_DEPTH):0] rob_cnt_t;

endpackage

`default_nettype wire

// ==== rtl/pipeline_pkg.sv ====
/* Pipeline slot record shared by rename, queue stage and ROB */
`default_nettype none

package pipeline_pkg;

	// Opcodes carried through rename, the encoding has no meaning here beyond NOP
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_AND = 4'd3,
		OP_OR  = 4'd4,
		OP_XOR = 4'd5,
		OP_SHL = 4'd6,
		OP_SHR = 4'd7,
		OP_LD  = 4'd8,
		OP_ST  = 4'd9,
		OP_BR  = 4'd10
	} opcode_t;

	// One renamed slot
	typedef struct packed {
		logic                   v;
		opcode_t                op;
		cpu_types_pkg::areg_t   rd;
		cpu_types_pkg::areg_t   rs1;
		cpu_types_pkg::areg_t   rs2;
		cpu_types_pkg::preg_t   pd;
		cpu_types_pkg::preg_t   ps1;
		cpu_types_pkg::preg_t   ps2;
		cpu_types_pkg::preg_t   old_pd;
		logic                   rdz;
		logic                   nop;
		cpu_types_pkg::rob_idx_t rob_id;
	} pipeline_reg_t;

	// Reset slot, an invalid NOP that writes no register
	function automatic pipeline_reg_t nop_slot();
		pipeline_reg_t s;
		s = '0;
		s.op = OP_NOP;
		s.rdz = 1'b1;
		s.nop = 1'b1;
		return s;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/free_list.sv ====
/* Circular FIFO of free physical tags. Resets holding the tags above the architectural
   registers in order; pop_cnt must not exceed free_count */
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module free_list (
	input  wire logic                                     clk,
	input  wire logic                                     rst,
	input  wire logic [2:0]                               pop_cnt,
	input  wire logic                                     push,
	input  wire cpu_types_pkg::preg_t                     push_tag,
	output cpu_types_pkg::preg_t [`RN_WIDTH-1:0]          pop_tags,
	output logic [$clog2(`RN_NUM_PREGS):0]                free_count
);

	localparam int PW = $clog2(`RN_NUM_PREGS);

	cpu_types_pkg::preg_t tags [0:`RN_NUM_PREGS-1];
	logic [PW-1:0] head;
	logic [PW-1:0] tail;

	// The next four tags are always visible at the head
	always_comb begin
		for (int k = 0; k < `RN_WIDTH; k++)
			pop_tags[k] = tags[PW'(head + PW'(k))];
	end

	// ========================================
	// Pointer and count update
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			// Tags 0 to NUM_AREGS-1 start out mapped, the rest are free
			for (int i = 0; i < `RN_NUM_PREGS - `RN_NUM_AREGS; i++)
				tags[i] <= cpu_types_pkg::preg_t'(i + `RN_NUM_AREGS);
			head <= '0;
			tail <= PW'(`RN_NUM_PREGS - `RN_NUM_AREGS);
			free_count <= (PW+1)'(`RN_NUM_PREGS - `RN_NUM_AREGS);
		end else begin
			if (push) begin
				tags[tail] <= push_tag;
				tail <= tail + 1'b1;
			end
			head <= head + PW'(pop_cnt);
			free_count <= free_count - (PW+1)'(pop_cnt) + (PW+1)'(push);
		end
	end

	// Rename acceptance must keep allocation within the free tags
	a_no_overpop: assert property (@(posedge clk) disable iff (rst)
		(PW+1)'(pop_cnt) <= free_count);

	// A freed tag can only come back if something was taken out earlier
	a_no_overpush: assert property (@(posedge clk) disable iff (rst)
		push |-> (free_count < (PW+1)'(`RN_NUM_PREGS)) || (pop_cnt != 3'd0));

endmodule

`default_nettype wire

// ==== rtl/rename_stage.sv ====
/* Four-wide rename into the ren registers. A group is taken whole or not at all; a stalled
   group is dropped and must be presented again by the source */
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module rename_stage (
	input  wire logic                                          clk,
	input  wire logic                                          rst,
	input  wire logic                                          pipe_en,
	input  wire logic [`RN_WIDTH-1:0]                          in_v,
	input  wire pipeline_pkg::opcode_t [`RN_WIDTH-1:0]         in_op,
	input  wire cpu_types_pkg::areg_t [`RN_WIDTH-1:0]          in_rd,
	input  wire cpu_types_pkg::areg_t [`RN_WIDTH-1:0]          in_rs1,
	input  wire cpu_types_pkg::areg_t [`RN_WIDTH-1:0]          in_rs2,
	input  wire logic                                          mm_active,
	input  wire cpu_types_pkg::preg_t [`RN_WIDTH-1:0]          pop_tags,
	input  wire logic [$clog2(`RN_NUM_PREGS):0]                free_count,
	input  wire cpu_types_pkg::rob_cnt_t                       rob_free,
	input  wire cpu_types_pkg::rob_idx_t                       rob_tail,
	output logic [2:0]                                         pop_cnt,
	output logic                                               stall,
	output pipeline_pkg::pipeline_reg_t [`RN_WIDTH-1:0]        ren,
	output logic                                               mm_active_ren
);

	cpu_types_pkg::preg_t map [0:`RN_NUM_AREGS-1];
	pipeline_pkg::pipeline_reg_t [`RN_WIDTH-1:0] slot_n;
	logic [`RN_WIDTH-1:0] wr;
	logic [2:0] inflight;
	cpu_types_pkg::rob_cnt_t eff_rob_free;
	logic accept;

	// The group sitting in ren enters the ROB on the same edge that takes the new group,
	// so its entries are counted against the free space and ahead of the tail
	always_comb begin
		inflight = 3'd0;
		for (int j = 0; j < `RN_WIDTH; j++)
			inflight = inflight + 3'(ren[j].v);
	end

	assign eff_rob_free = rob_free - cpu_types_pkg::rob_cnt_t'(inflight);
	assign accept = pipe_en && (free_count >= 7'(`RN_WIDTH))
		&& (eff_rob_free >= cpu_types_pkg::rob_cnt_t'(`RN_WIDTH));
	assign stall = pipe_en && !accept;

	// ========================================
	// Slot formation
	// ========================================
	always_comb begin
		logic [2:0] wr_rank;
		logic [2:0] v_rank;
		wr_rank = 3'd0;
		v_rank = 3'd0;
		for (int j = 0; j < `RN_WIDTH; j++) begin
			wr[j] = in_v[j] && (in_rd[j] != '0);
			slot_n[j].v = in_v[j] && accept;
			slot_n[j].op = in_op[j];
			slot_n[j].rd = in_rd[j];
			slot_n[j].rs1 = in_rs1[j];
			slot_n[j].rs2 = in_rs2[j];
			slot_n[j].rdz = (in_rd[j] == '0);
			slot_n[j].nop = (in_op[j] == pipeline_pkg::OP_NOP);
			// Writing slots take free tags in rank order
			slot_n[j].pd = wr[j] ? pop_tags[wr_rank[1:0]] : '0;
			slot_n[j].ps1 = map[in_rs1[j]];
			slot_n[j].ps2 = map[in_rs2[j]];
			slot_n[j].old_pd = map[in_rd[j]];
			// Earlier writers in the group override the map and the youngest one wins
			for (int i = 0; i < j; i++) begin
				if (wr[i] && in_rd[i] == in_rs1[j])
					slot_n[j].ps1 = slot_n[i].pd;
				if (wr[i] && in_rd[i] == in_rs2[j])
					slot_n[j].ps2 = slot_n[i].pd;
				if (wr[i] && in_rd[i] == in_rd[j])
					slot_n[j].old_pd = slot_n[i].pd;
			end
			slot_n[j].rob_id = rob_tail + cpu_types_pkg::rob_idx_t'(inflight)
				+ cpu_types_pkg::rob_idx_t'(v_rank);
			v_rank = v_rank + 3'(in_v[j]);
			wr_rank = wr_rank + 3'(wr[j]);
		end
		pop_cnt = accept ? wr_rank : 3'd0;
	end

	// ========================================
	// Map table and ren registers
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int a = 0; a < `RN_NUM_AREGS; a++)
				map[a] <= cpu_types_pkg::preg_t'(a);
			for (int j = 0; j < `RN_WIDTH; j++)
				ren[j] <= pipeline_pkg::nop_slot();
			mm_active_ren <= 1'b0;
		end else if (pipe_en) begin
			// Slot v already folds in accept, so a stalled group lands as all invalid
			for (int j = 0; j < `RN_WIDTH; j++)
				ren[j] <= slot_n[j];
			mm_active_ren <= mm_active;
			// Later slots write last, so the youngest writer of an rd wins
			if (accept) begin
				for (int j = 0; j < `RN_WIDTH; j++)
					if (wr[j])
						map[in_rd[j]] <= slot_n[j].pd;
			end
		end
	end

	// A freshly allocated tag is never read or displaced by the slot that takes it
	for (genvar g = 0; g < `RN_WIDTH; g++) begin : g_tag_chk
		a_new_tag_distinct: assert property (@(posedge clk) disable iff (rst)
			(ren[g].v && !ren[g].rdz) |-> (ren[g].pd != ren[g].ps1)
				&& (ren[g].pd != ren[g].ps2) && (ren[g].pd != ren[g].old_pd));
	end

endmodule

`default_nettype wire

// ==== rtl/pipeline_que.sv ====
/* Queue stage beside the ROB enqueue. Each lane keeps its last valid slot for bypass,
   invalid slots leave the lane untouched */
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module pipeline_que (
	input  wire logic                                          clk,
	input  wire logic                                          rst,
	input  wire logic                                          en,
	input  wire pipeline_pkg::pipeline_reg_t [`RN_WIDTH-1:0]   ren,
	input  wire logic                                          mm_active_ren,
	output pipeline_pkg::pipeline_reg_t [`RN_WIDTH-1:0]        que,
	output logic                                               mm_active_que
);

	// ========================================
	// Per-lane hold registers
	// ========================================
	for (genvar g = 0; g < `RN_WIDTH; g++) begin : g_lane
		always_ff @(posedge clk) begin
			if (rst)
				que[g] <= pipeline_pkg::nop_slot();
			else if (en && ren[g].v)
				// Same values the ROB captures on this edge
				que[g] <= ren[g];
		end
	end

	// The active flag follows every enabled edge, valid or not
	always_ff @(posedge clk) begin
		if (rst)
			mm_active_que <= 1'b0;
		else if (en)
			mm_active_que <= mm_active_ren;
	end

endmodule

`default_nettype wire

// ==== rtl/reorder_buffer.sv ====
/* In-order ROB with a compacting four-wide enqueue and one retire per cycle. The commit
   outputs are combinational from the head and only meaningful while commit_v is high */
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module reorder_buffer (
	input  wire logic                                          clk,
	input  wire logic                                          rst,
	input  wire logic                                          en,
	input  wire pipeline_pkg::pipeline_reg_t [`RN_WIDTH-1:0]   ren,
	input  wire logic                                          commit_en,
	output cpu_types_pkg::rob_idx_t                            rob_tail,
	output cpu_types_pkg::rob_cnt_t                            rob_free,
	output logic                                               commit_v,
	output cpu_types_pkg::areg_t                               commit_rd,
	output cpu_types_pkg::preg_t                               commit_pd,
	output cpu_types_pkg::preg_t                               commit_old_pd,
	output logic                                               commit_rdz
);

	pipeline_pkg::pipeline_reg_t entries [0:`RN_ROB_DEPTH-1];
	cpu_types_pkg::rob_idx_t head;
	cpu_types_pkg::rob_cnt_t count;
	cpu_types_pkg::rob_idx_t [`RN_WIDTH-1:0] enq_idx;
	cpu_types_pkg::rob_cnt_t enq_cnt;
	logic deq;

	// Valid slots pack into consecutive entries from the tail
	always_comb begin
		logic [2:0] rank;
		rank = 3'd0;
		for (int j = 0; j < `RN_WIDTH; j++) begin
			enq_idx[j] = rob_tail + cpu_types_pkg::rob_idx_t'(rank);
			rank = rank + 3'(ren[j].v);
		end
		enq_cnt = en ? cpu_types_pkg::rob_cnt_t'(rank) : '0;
	end

	assign rob_free = cpu_types_pkg::rob_cnt_t'(`RN_ROB_DEPTH) - count;
	assign commit_v = (count != '0);
	assign commit_rd = entries[head].rd;
	assign commit_pd = entries[head].pd;
	assign commit_old_pd = entries[head].old_pd;
	assign commit_rdz = entries[head].rdz;
	assign deq = commit_en && commit_v;

	// ========================================
	// Entry array and pointers
	// ========================================
	always_ff @(posedge clk) begin
		if (en) begin
			for (int j = 0; j < `RN_WIDTH; j++)
				if (ren[j].v)
					entries[enq_idx[j]] <= ren[j];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			rob_tail <= '0;
			count <= '0;
		end else begin
			rob_tail <= rob_tail + cpu_types_pkg::rob_idx_t'(enq_cnt);
			if (deq)
				head <= head + 1'b1;
			count <= count + enq_cnt - cpu_types_pkg::rob_cnt_t'(deq);
		end
	end

	// Rename reserves room a cycle ahead, so an enqueue always fits
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		enq_cnt <= rob_free);

endmodule

`default_nettype wire

// ==== rtl/rename_top.sv ====
/* Rename slice top. The source must hold a group while stall is high */
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module rename_top (
	input  wire logic                                          clk,
	input  wire logic                                          rst,
	input  wire logic                                          pipe_en,
	input  wire logic [`RN_WIDTH-1:0]                          in_v,
	input  wire pipeline_pkg::opcode_t [`RN_WIDTH-1:0]         in_op,
	input  wire cpu_types_pkg::areg_t [`RN_WIDTH-1:0]          in_rd,
	input  wire cpu_types_pkg::areg_t [`RN_WIDTH-1:0]          in_rs1,
	input  wire cpu_types_pkg::areg_t [`RN_WIDTH-1:0]          in_rs2,
	input  wire logic                                          mm_active,
	input  wire logic                                          commit_en,
	output logic                                               stall,
	output pipeline_pkg::pipeline_reg_t [`RN_WIDTH-1:0]        que,
	output logic                                               mm_active_que,
	output logic                                               commit_v,
	output cpu_types_pkg::areg_t                               commit_rd,
	output cpu_types_pkg::preg_t                               commit_pd,
	output cpu_types_pkg::preg_t                               commit_old_pd
);

	cpu_types_pkg::preg_t [`RN_WIDTH-1:0] pop_tags;
	logic [$clog2(`RN_NUM_PREGS):0] free_count;
	logic [2:0] pop_cnt;
	logic push;
	cpu_types_pkg::rob_cnt_t rob_free;
	cpu_types_pkg::rob_idx_t rob_tail;
	pipeline_pkg::pipeline_reg_t [`RN_WIDTH-1:0] ren;
	logic mm_active_ren;
	logic commit_rdz;

	// A retiring writer returns the tag it displaced, register zero owns none
	assign push = commit_en && commit_v && !commit_rdz;

	free_list u_free_list (
		.clk(clk), .rst(rst), .pop_cnt(pop_cnt), .push(push), .push_tag(commit_old_pd),
		.pop_tags(pop_tags), .free_count(free_count)
	);

	rename_stage u_rename (
		.clk(clk), .rst(rst), .pipe_en(pipe_en), .in_v(in_v), .in_op(in_op),
		.in_rd(in_rd), .in_rs1(in_rs1), .in_rs2(in_rs2), .mm_active(mm_active),
		.pop_tags(pop_tags), .free_count(free_count), .rob_free(rob_free),
		.rob_tail(rob_tail), .pop_cnt(pop_cnt), .stall(stall), .ren(ren),
		.mm_active_ren(mm_active_ren)
	);

	// Queue stage and ROB load the same ren group on the same enabled edge
	pipeline_que u_que (
		.clk(clk), .rst(rst), .en(pipe_en), .ren(ren), .mm_active_ren(mm_active_ren),
		.que(que), .mm_active_que(mm_active_que)
	);

	reorder_buffer u_rob (
		.clk(clk), .rst(rst), .en(pipe_en), .ren(ren), .commit_en(commit_en),
		.rob_tail(rob_tail), .rob_free(rob_free), .commit_v(commit_v),
		.commit_rd(commit_rd), .commit_pd(commit_pd), .commit_old_pd(commit_old_pd),
		.commit_rdz(commit_rdz)
	);

endmodule

`default_nettype wire

// ==== dv/rename_top_tb.sv ====
/* Testbench for rename_top. Inputs change on the rising edge, and outputs are checked on the
   falling edge against a model map table, a free-tag queue and a ROB queue */
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module rename_top_tb;

	typedef pipeline_pkg::pipeline_reg_t [`RN_WIDTH-1:0] group_t;

	logic clk;
	logic rst;
	logic pipe_en;
	logic [`RN_WIDTH-1:0] in_v;
	pipeline_pkg::opcode_t [`RN_WIDTH-1:0] in_op;
	cpu_types_pkg::areg_t [`RN_WIDTH-1:0] in_rd;
	cpu_types_pkg::areg_t [`RN_WIDTH-1:0] in_rs1;
	cpu_types_pkg::areg_t [`RN_WIDTH-1:0] in_rs2;
	logic mm_active;
	logic commit_en;
	logic stall;
	group_t que;
	logic mm_active_que;
	logic commit_v;
	cpu_types_pkg::areg_t commit_rd;
	cpu_types_pkg::preg_t commit_pd;
	cpu_types_pkg::preg_t commit_old_pd;

	// Model state describes the DUT as it stands between two rising edges
	cpu_types_pkg::preg_t m_map [0:`RN_NUM_AREGS-1];
	cpu_types_pkg::preg_t free_q [$];
	pipeline_pkg::pipeline_reg_t rob_q [$];
	group_t m_ren;
	group_t exp_que;
	logic m_mm_ren;
	logic exp_mm_que;
	int enq_total;
	logic exp_accept;

	// DUT status sampled on the falling edge for the stimulus loops
	logic stall_now;
	logic commit_v_now;
	logic taken_now;
	int errors;
	int timeouts;
	int n;

	rename_top UUT (
		.clk(clk), .rst(rst), .pipe_en(pipe_en), .in_v(in_v), .in_op(in_op), .in_rd(in_rd),
		.in_rs1(in_rs1), .in_rs2(in_rs2), .mm_active(mm_active), .commit_en(commit_en),
		.stall(stall), .que(que), .mm_active_que(mm_active_que), .commit_v(commit_v),
		.commit_rd(commit_rd), .commit_pd(commit_pd), .commit_old_pd(commit_old_pd)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ========================================
	// Reference model
	// ========================================
	task automatic init_model();
		m_map = '{default: '0};
		for (int a = 0; a < `RN_NUM_AREGS; a++)
			m_map[a] = cpu_types_pkg::preg_t'(a);
		free_q.delete();
		for (int t = `RN_NUM_AREGS; t < `RN_NUM_PREGS; t++)
			free_q.push_back(cpu_types_pkg::preg_t'(t));
		rob_q.delete();
		for (int j = 0; j < `RN_WIDTH; j++) begin
			m_ren[j] = pipeline_pkg::nop_slot();
			exp_que[j] = pipeline_pkg::nop_slot();
		end
		m_mm_ren = 1'b0;
		exp_mm_que = 1'b0;
		enq_total = 0;
		exp_accept = 1'b0;
	endtask

	// Renames the presented group in program order, so a later slot naturally sees the
	// tags written by earlier slots of the same group
	function automatic group_t rename_group(input logic acc, input int tail);
		group_t g;
		int rank;
		rank = 0;
		for (int j = 0; j < `RN_WIDTH; j++) begin
			g[j] = pipeline_pkg::nop_slot();
			if (acc && in_v[j]) begin
				g[j].v = 1'b1;
				g[j].op = in_op[j];
				g[j].rd = in_rd[j];
				g[j].rs1 = in_rs1[j];
				g[j].rs2 = in_rs2[j];
				g[j].rdz = (in_rd[j] == '0);
				g[j].nop = (in_op[j] == pipeline_pkg::OP_NOP);
				g[j].ps1 = m_map[in_rs1[j]];
				g[j].ps2 = m_map[in_rs2[j]];
				g[j].old_pd = m_map[in_rd[j]];
				g[j].pd = '0;
				g[j].rob_id = cpu_types_pkg::rob_idx_t'(tail + rank);
				rank++;
				// Register zero never gets a tag of its own
				if (!g[j].rdz) begin
					g[j].pd = free_q.pop_front();
					m_map[in_rd[j]] = g[j].pd;
				end
			end
		end
		return g;
	endfunction

	// Applies one rising edge with the retire first, then the enqueue of the ren group
	// and then the new rename
	task automatic advance_model();
		pipeline_pkg::pipeline_reg_t head;
		logic push_pending;
		push_pending = 1'b0;
		if (commit_en && rob_q.size() != 0) begin
			head = rob_q.pop_front();
			push_pending = !head.rdz;
		end
		if (pipe_en) begin
			for (int j = 0; j < `RN_WIDTH; j++)
				if (m_ren[j].v) begin
					exp_que[j] = m_ren[j];
					rob_q.push_back(m_ren[j]);
					enq_total++;
				end
			exp_mm_que = m_mm_ren;
			m_ren = rename_group(exp_accept, enq_total);
			m_mm_ren = mm_active;
		end
		// The freed tag lands behind everything popped on the same edge
		if (push_pending)
			free_q.push_back(head.old_pd);
	endtask

	// ========================================
	// Checks
	// ========================================
	task automatic report_mismatch(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		errors++;
		$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic check_outputs();
		assert (stall === (pipe_en && !exp_accept))
			else report_mismatch("stall", 64'(stall), 64'(pipe_en && !exp_accept));
		assert (commit_v === (rob_q.size() != 0))
			else report_mismatch("commit_v", 64'(commit_v), 64'(rob_q.size() != 0));
		if (rob_q.size() != 0) begin
			assert (commit_rd === rob_q[0].rd)
				else report_mismatch("commit_rd", 64'(commit_rd), 64'(rob_q[0].rd));
			assert (commit_pd === rob_q[0].pd)
				else report_mismatch("commit_pd", 64'(commit_pd), 64'(rob_q[0].pd));
			assert (commit_old_pd === rob_q[0].old_pd)
				else report_mismatch("commit_old_pd", 64'(commit_old_pd),
					64'(rob_q[0].old_pd));
		end
		for (int j = 0; j < `RN_WIDTH; j++)
			assert (que[j] === exp_que[j])
				else report_mismatch($sformatf("que lane %0d", j), 64'(que[j]),
					64'(exp_que[j]));
		assert (mm_active_que === exp_mm_que)
			else report_mismatch("mm_active_que", 64'(mm_active_que), 64'(exp_mm_que));
	endtask

	always @(negedge clk) begin
		int inflight;
		if (rst) begin
			init_model();
		end else begin
			// The group still in ren takes ROB room on the coming edge
			inflight = 0;
			for (int j = 0; j < `RN_WIDTH; j++)
				if (m_ren[j].v)
					inflight++;
			exp_accept = pipe_en && (free_q.size() >= `RN_WIDTH)
				&& (`RN_ROB_DEPTH - rob_q.size() - inflight >= `RN_WIDTH);
			check_outputs();
			advance_model();
		end
		stall_now = stall;
		commit_v_now = commit_v;
		taken_now = pipe_en && !stall;
	end

	// ========================================
	// Stimulus
	// ========================================
	// A group is replaced only after it was taken and a stalled group is held for retry
	task automatic drive_step(input int en_pct, input int v_pct, input int commit_pct);
		logic [`RN_WIDTH-1:0] v;
		pipeline_pkg::opcode_t [`RN_WIDTH-1:0] op;
		cpu_types_pkg::areg_t [`RN_WIDTH-1:0] rd;
		cpu_types_pkg::areg_t [`RN_WIDTH-1:0] rs1;
		cpu_types_pkg::areg_t [`RN_WIDTH-1:0] rs2;
		int span;
		if (exp_accept) begin
			// A narrow register range most of the time makes same-group hazards common
			span = ($urandom_range(0, 3) == 0) ? `RN_NUM_AREGS - 1 : 7;
			for (int j = 0; j < `RN_WIDTH; j++) begin
				v[j] = ($urandom_range(0, 99) < v_pct);
				op[j] = pipeline_pkg::opcode_t'($urandom_range(0, 10));
				rd[j] = cpu_types_pkg::areg_t'($urandom_range(0, span));
				rs1[j] = cpu_types_pkg::areg_t'($urandom_range(0, span));
				rs2[j] = cpu_types_pkg::areg_t'($urandom_range(0, span));
			end
			in_v <= v;
			in_op <= op;
			in_rd <= rd;
			in_rs1 <= rs1;
			in_rs2 <= rs2;
		end
		pipe_en <= ($urandom_range(0, 99) < en_pct);
		mm_active <= 1'($urandom_range(0, 1));
		commit_en <= ($urandom_range(0, 99) < commit_pct);
	endtask

	initial begin
		errors = 0;
		timeouts = 0;
		void'($urandom(32'ha167));
		rst = 1'b1;
		pipe_en = 1'b0;
		in_v = '0;
		in_op = '{default: pipeline_pkg::OP_NOP};
		in_rd = '0;
		in_rs1 = '0;
		in_rs2 = '0;
		mm_active = 1'b0;
		commit_en = 1'b0;
		stall_now = 1'b0;
		commit_v_now = 1'b0;
		taken_now = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// Random traffic with gaps in pipe_en and in commits
		repeat (300) begin
			@(posedge clk);
			drive_step(85, 80, 70);
		end

		// Without commits the ROB fills up and rename must stall
		n = 0;
		while (!stall_now && n < 60) begin
			@(posedge clk);
			drive_step(100, 80, 0);
			n++;
		end
		if (!stall_now) begin
			timeouts++;
			$display("Timeout: stall never rose while commits were held off");
		end
		repeat (8) begin
			@(posedge clk);
			drive_step(100, 80, 0);
		end

		// Commits resume and the held group must be taken again
		n = 0;
		while (!taken_now && n < 60) begin
			@(posedge clk);
			drive_step(100, 80, 100);
			n++;
		end
		if (!taken_now) begin
			timeouts++;
			$display("Timeout: rename never accepted again after commits resumed");
		end
		repeat (200) begin
			@(posedge clk);
			drive_step(85, 80, 60);
		end

		// Drain the ROB with empty groups
		n = 0;
		while (commit_v_now && n < 100) begin
			@(posedge clk);
			drive_step(100, 0, 100);
			n++;
		end
		if (commit_v_now) begin
			timeouts++;
			$display("Timeout: the ROB did not drain");
		end
		repeat (4) @(posedge clk);

		$display("Run finished with %0d mismatches and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/pipeline_pkg.sv
rtl/free_list.sv
rtl/rename_stage.sv
rtl/pipeline_que.sv
rtl/reorder_buffer.sv
rtl/rename_top.sv
dv/rename_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the rename slice testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module rename_top_tb -Mdir obj_dir -o rename_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rename_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
